// ==== tb/dbg_patterns.txt ====
# S <sel> <data hex>: one debug strobe, sel 1 loads the address pointer
# W <cycles>: idle cycles    C <signal> <hex>: expected value of a DUT output or errcnt
C led 0
C programn 1
C overflow 0
# LED write, the register changes two edges after the data strobe
S 1 20000000
S 0 1234BEEF
W 1
C led 0
W 1
C led BEEF
W 40
C errcnt 0
# output, output enable, set alias and clear alias in turn
S 1 20000048
S 0 CA5A5A5A
S 0 FFFF0000
S 0 00000F0F
S 0 000A0005
W 40
C genio_out 0A505F5A
C genio_oe 3FFF0000
# flash select without the reload key
S 1 20000034
S 0 12345601
W 5
C fsel_c 1
W 3
C fsel_c 0
W 40
C fsel_d 1
C programn 1
C fsel_c 0
# region 5 is rejected twice
S 1 50000000
S 0 0000FFFF
S 0 FFFFFFFF
W 40
C errcnt 2
C led BEEF
C genio_out 0A505F5A
C genio_oe 3FFF0000
C fsel_d 1
# back to back strobes, same word everywhere so drops do not matter
S 1 20000000
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
S 0 E468ACE0
W 40
C overflow 1
C led ACE0
C fsel_d 0
C genio_out 0
C genio_oe 2468ACE0
C programn 1
C fsel_c 0
C errcnt 2
# flash select with the reload key
S 1 20000034
S 0 D0F1A501
W 40
C programn 0
C fsel_d 1
C fsel_c 0
C overflow 1

// ==== src.f ====
+incdir+common
common/soc_dbg_pkg.sv
dbg_loader/dbg_fifo.sv
dbg_loader/dbg_mem_writer.sv
source/misc_regs.sv
source/flash_sel_seq.sv
source/soc_dbg_top.sv
tb/tb_soc_dbg.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_soc_dbg
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_soc_dbg.sv ====
// Testbench for the debug loader top level
// Replays tb/dbg_patterns.txt against the DUT: debug port
// strobes, idle gaps and checks of the register outputs and
// of a count of bus error pulses.

`timescale 1ns/1ps
`default_nettype none

`include "soc_dbg_defines.svh"

module tb_soc_dbg;

	localparam string PATTERN_FILE    = "tb/dbg_patterns.txt";
	localparam int    CYCLES_PER_LINE = 50;
	localparam int    RESET_CYCLES    = 8;

	logic                   clk48m = 1'b0;
	logic                   rst;
	logic                   dbg_strobe;
	logic                   dbg_sel;
	logic [`DBG_DATA_W-1:0] dbg_data;
	logic [`LED_W-1:0]      led;
	logic [`GENIO_W-1:0]    genio_out;
	logic [`GENIO_W-1:0]    genio_oe;
	logic                   fsel_d;
	logic                   fsel_c;
	logic                   programn;
	logic                   bus_error;
	logic                   overflow;

	int    err_count   = 0;
	int    cycle_count = 0;
	int    cycle_limit = 0;
	string lines[$];

	soc_dbg_top i_soc_dbg_top (
		.clk48m       (clk48m),
		.rst          (rst),
		.dbg_strobe_i (dbg_strobe),
		.dbg_sel_i    (dbg_sel),
		.dbg_data_i   (dbg_data),
		.led_o        (led),
		.genio_out_o  (genio_out),
		.genio_oe_o   (genio_oe),
		.fsel_d_o     (fsel_d),
		.fsel_c_o     (fsel_c),
		.programn_o   (programn),
		.bus_error_o  (bus_error),
		.overflow_o   (overflow)
	);

	// 20 ns period
	always #10 clk48m = ~clk48m;

	// one count per rejected write
	always @(posedge clk48m) begin
		if (rst) begin
			err_count <= 0;
		end else if (bus_error) begin
			err_count <= err_count + 1;
		end
	end

	always @(posedge clk48m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the patterns did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$fatal(1, "simulation timeout");
		end
	end

	// --------------------------------------------------
	// pattern file
	// --------------------------------------------------
	task automatic load_patterns();
		int    fd;
		string line;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("could not open the pattern file %0s", PATTERN_FILE);
			$display("Testbench failed");
			$fatal(1, "missing pattern file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// skip comments and blank lines
				if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n"
					&& line.getc(0) != "\r" && line.getc(0) != " ") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	// inputs change 1 ns after the edge, strobe lasts one cycle
	task automatic send_entry(input logic sel, input logic [`DBG_DATA_W-1:0] value);
		dbg_strobe = 1'b1;
		dbg_sel    = sel;
		dbg_data   = value;
		@(posedge clk48m);
		#1;
		dbg_strobe = 1'b0;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk48m);
			#1;
		end
	endtask

	task automatic check_signal(input string name, input logic [31:0] expected);
		logic [31:0] actual;
		bit          known;
		known  = 1'b1;
		actual = '0;
		if (name == "led") begin
			actual = 32'(led);
		end else if (name == "genio_out") begin
			actual = 32'(genio_out);
		end else if (name == "genio_oe") begin
			actual = 32'(genio_oe);
		end else if (name == "fsel_d") begin
			actual = 32'(fsel_d);
		end else if (name == "fsel_c") begin
			actual = 32'(fsel_c);
		end else if (name == "programn") begin
			actual = 32'(programn);
		end else if (name == "overflow") begin
			actual = 32'(overflow);
		end else if (name == "errcnt") begin
			actual = 32'(err_count);
		end else begin
			known = 1'b0;
		end
		if (!known) begin
			$display("the pattern file names an unknown signal: %0s", name);
			$display("Testbench failed");
			$fatal(1, "unknown signal");
		end else begin
			assert (actual == expected) else begin
				$display("ERROR at %0d ns: %0s expected %h, actual %h",
					$time, name, expected, actual);
				$display("Testbench failed");
				$fatal(1, "value mismatch");
			end
		end
	endtask

	task automatic run_line(input string line);
		logic [7:0]  cmd;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		string       name;
		int          count;
		bit          bad;
		cmd = line.getc(0);
		bad = 1'b0;
		case (cmd)
			"S": begin
				if ($sscanf(line, "S %h %h", arg_a, arg_b) == 2) begin
					send_entry(arg_a[0], arg_b);
				end else begin
					bad = 1'b1;
				end
			end
			"W": begin
				if ($sscanf(line, "W %d", count) == 1) begin
					idle_cycles(count);
				end else begin
					bad = 1'b1;
				end
			end
			"C": begin
				if ($sscanf(line, "C %s %h", name, arg_b) == 2) begin
					check_signal(name, arg_b);
				end else begin
					bad = 1'b1;
				end
			end
			default: bad = 1'b1;
		endcase
		if (bad) begin
			$display("malformed line in the pattern file: %0s", line);
			$display("Testbench failed");
			$fatal(1, "bad pattern line");
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		rst        = 1'b1;
		dbg_strobe = 1'b0;
		dbg_sel    = 1'b0;
		dbg_data   = '0;
		load_patterns();
		cycle_limit = lines.size() * CYCLES_PER_LINE;
		repeat (RESET_CYCLES) @(posedge clk48m);
		#1;
		rst = 1'b0;
		foreach (lines[i]) begin
			run_line(lines[i]);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/soc_dbg_top.sv ====
// Debug loader top level
// Debug port entries are queued, written over the internal bus
// into the misc register block, and the flash-select register
// drives the chip select and reprogram sequencer.

`timescale 1ns/1ps
`default_nettype none

`include "soc_dbg_defines.svh"

module soc_dbg_top (
	input  logic                   clk48m,
	input  logic                   rst,
	input  logic                   dbg_strobe_i,
	input  logic                   dbg_sel_i,
	input  logic [`DBG_DATA_W-1:0] dbg_data_i,
	output logic [`LED_W-1:0]      led_o,
	output logic [`GENIO_W-1:0]    genio_out_o,
	output logic [`GENIO_W-1:0]    genio_oe_o,
	output logic                   fsel_d_o,
	output logic                   fsel_c_o,
	output logic                   programn_o,
	output logic                   bus_error_o,
	output logic                   overflow_o
);
	import soc_dbg_pkg::*;

	dbg_entry_t port_entry;
	dbg_entry_t head;
	logic       empty;
	logic       pop;
	bus_req_t   req;
	logic       valid;
	logic       ready;
	logic       fsel_strobe;
	logic       reload_req;

	// select bit on top, data below
	assign port_entry = {dbg_sel_i, dbg_data_i};

	// --------------------------------------------------
	// loader
	// --------------------------------------------------
	dbg_fifo #(
		.DEPTH(`DBG_FIFO_DEPTH)
	) i_fifo (
		.clk48m     (clk48m),
		.rst        (rst),
		.wr_i       (dbg_strobe_i),
		.wr_entry_i (port_entry),
		.pop_i      (pop),
		.head_o     (head),
		.empty_o    (empty),
		.overflow_o (overflow_o)
	);

	dbg_mem_writer i_writer (
		.clk48m  (clk48m),
		.rst     (rst),
		.head_i  (head),
		.empty_i (empty),
		.pop_o   (pop),
		.req_o   (req),
		.valid_o (valid),
		.ready_i (ready)
	);

	// --------------------------------------------------
	// register target and flash select
	// --------------------------------------------------
	misc_regs i_regs (
		.clk48m        (clk48m),
		.rst           (rst),
		.req_i         (req),
		.valid_i       (valid),
		.ready_o       (ready),
		.bus_error_o   (bus_error_o),
		.led_o         (led_o),
		.genio_out_o   (genio_out_o),
		.genio_oe_o    (genio_oe_o),
		.fsel_d_o      (fsel_d_o),
		.fsel_strobe_o (fsel_strobe),
		.reload_req_o  (reload_req)
	);

	flash_sel_seq i_fsel (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_strobe_i (fsel_strobe),
		.reload_req_i  (reload_req),
		.fsel_c_o      (fsel_c_o),
		.programn_o    (programn_o)
	);

endmodule

`default_nettype wire

// ==== source/flash_sel_seq.sv ====
// Flash select delay sequencer
// After a flash-select write, counts down and raises the chip
// select inside a fixed window so the selection is settled
// before a requested reprogram pulls programn low.

`timescale 1ns/1ps
`default_nettype none

`include "soc_dbg_defines.svh"

module flash_sel_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_strobe_i,
	input  logic reload_req_i,
	output logic fsel_c_o,
	output logic programn_o
);

	logic [2:0] delay_cnt;
	logic       reload_pending;
	logic       reload_fired;

	assign fsel_c_o   = (delay_cnt <= `FSEL_C_HI) && (delay_cnt >= `FSEL_C_LO);
	assign programn_o = ~reload_fired;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			delay_cnt      <= '0;
			reload_pending <= 1'b0;
			reload_fired   <= 1'b0;
		end else begin
			if (fsel_strobe_i) begin
				delay_cnt <= `FSEL_DELAY_START;
				if (reload_req_i) begin
					reload_pending <= 1'b1;
				end
			end else if (delay_cnt != 3'd0) begin
				delay_cnt <= delay_cnt - 1'b1;
				// count leaving 1, reprogram now and stay there
				if (delay_cnt == 3'd1 && reload_pending) begin
					reload_fired <= 1'b1;
				end
			end
		end
	end

	// reload request only ever comes with a flash-select write
	a_reload_with_strobe: assert property (@(posedge clk48m) disable iff (rst)
		reload_req_i |-> fsel_strobe_i);

endmodule

`default_nettype wire

// ==== source/misc_regs.sv ====
// Misc register block
// Bus target for the debug writer. Decodes the region nibble,
// updates the LED, general I/O and flash-select registers in
// the misc region and flags writes to any other region as a
// bus error. Every request is accepted in the cycle it appears.

`timescale 1ns/1ps
`default_nettype none

`include "soc_dbg_defines.svh"

module misc_regs (
	input  logic                  clk48m,
	input  logic                  rst,
	input  soc_dbg_pkg::bus_req_t req_i,
	input  logic                  valid_i,
	output logic                  ready_o,
	output logic                  bus_error_o,
	output logic [`LED_W-1:0]     led_o,
	output logic [`GENIO_W-1:0]   genio_out_o,
	output logic [`GENIO_W-1:0]   genio_oe_o,
	output logic                  fsel_d_o,
	output logic                  fsel_strobe_o,
	output logic                  reload_req_o
);
	import soc_dbg_pkg::*;

	logic      misc_hit;
	logic      wr_en;
	logic      is_reload;
	misc_reg_e reg_idx;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	assign ready_o   = valid_i;
	assign misc_hit  = (req_i.addr[31:28] == `MISC_REGION);
	assign reg_idx   = misc_reg_e'(req_i.addr[6:2]);
	assign wr_en     = valid_i && ready_o && misc_hit;
	assign is_reload = (req_i.wdata[31:8] == `FSEL_RELOAD_KEY);

	// --------------------------------------------------
	// register writes
	// --------------------------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o         <= '0;
			genio_out_o   <= '0;
			genio_oe_o    <= '0;
			fsel_d_o      <= 1'b0;
			fsel_strobe_o <= 1'b0;
			reload_req_o  <= 1'b0;
			bus_error_o   <= 1'b0;
		end else begin
			fsel_strobe_o <= 1'b0;
			reload_req_o  <= 1'b0;
			// nothing outside the misc region answers
			bus_error_o   <= valid_i && ready_o && !misc_hit;
			if (wr_en) begin
				case (reg_idx)
					REG_LED: begin
						led_o <= req_i.wdata[`LED_W-1:0];
					end
					REG_GENIO_OUT: begin
						genio_out_o <= req_i.wdata[`GENIO_W-1:0];
					end
					REG_GENIO_OE: begin
						genio_oe_o <= req_i.wdata[`GENIO_W-1:0];
					end
					REG_GENIO_W2S: begin
						genio_out_o <= genio_out_o | req_i.wdata[`GENIO_W-1:0];
					end
					REG_GENIO_W2C: begin
						genio_out_o <= genio_out_o & ~req_i.wdata[`GENIO_W-1:0];
					end
					REG_FLASH_SEL: begin
						fsel_d_o      <= req_i.wdata[0];
						fsel_strobe_o <= 1'b1;
						// magic key in the upper bits arms a reprogram
						reload_req_o  <= is_reload;
					end
					default: ;
				endcase
			end
		end
	end

	// the writer never repeats a request, so strobes stay single
	a_strobe_single: assert property (@(posedge clk48m) disable iff (rst)
		fsel_strobe_o |=> !fsel_strobe_o);

endmodule

`default_nettype wire

// ==== dbg_loader/dbg_mem_writer.sv ====
// Debug memory writer
// Drains the debug queue. Address entries reload the write
// pointer, data entries become one bus write at the pointer,
// after which the pointer steps to the next word.

`timescale 1ns/1ps
`default_nettype none

`include "soc_dbg_defines.svh"

module dbg_mem_writer (
	input  logic                    clk48m,
	input  logic                    rst,
	input  soc_dbg_pkg::dbg_entry_t head_i,
	input  logic                    empty_i,
	output logic                    pop_o,
	output soc_dbg_pkg::bus_req_t   req_o,
	output logic                    valid_o,
	input  logic                    ready_i
);
	import soc_dbg_pkg::*;

	logic [`DBG_DATA_W-1:0] addr_ptr;
	bus_req_t               req_q;

	// --------------------------------------------------
	// queue side
	// --------------------------------------------------
	// take the head only while no write is outstanding
	assign pop_o = !empty_i && !valid_o;
	assign req_o = req_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			addr_ptr <= '0;
			valid_o  <= 1'b0;
		end else begin
			if (valid_o && ready_i) begin
				valid_o  <= 1'b0;
				// next word
				addr_ptr <= addr_ptr + `DBG_DATA_W'(4);
			end else if (pop_o) begin
				if (head_i.is_addr) begin
					addr_ptr <= head_i.data;
				end else begin
					valid_o <= 1'b1;
				end
			end
		end
	end

	// --------------------------------------------------
	// request payload
	// --------------------------------------------------
	always_ff @(posedge clk48m) begin
		if (pop_o && !head_i.is_addr) begin
			req_q.addr  <= addr_ptr;
			req_q.wdata <= head_i.data;
		end
	end

	// the target accepts at once, so a request never lingers
	a_valid_drops: assert property (@(posedge clk48m) disable iff (rst)
		valid_o |=> !valid_o);

endmodule

`default_nettype wire

// ==== dbg_loader/dbg_fifo.sv ====
// Debug entry queue
// Captures each debug port strobe as one entry in a circular
// buffer. The port cannot be stalled, so a strobe that finds
// the queue full is lost and flagged in a sticky overflow bit.

`timescale 1ns/1ps
`default_nettype none

`include "soc_dbg_defines.svh"

module dbg_fifo #(
	parameter int DEPTH = `DBG_FIFO_DEPTH
) (
	input  logic                    clk48m,
	input  logic                    rst,
	input  logic                    wr_i,
	input  soc_dbg_pkg::dbg_entry_t wr_entry_i,
	input  logic                    pop_i,
	output soc_dbg_pkg::dbg_entry_t head_o,
	output logic                    empty_o,
	output logic                    overflow_o
);
	import soc_dbg_pkg::*;

	// pointer width
	localparam int AW = (DEPTH == `DBG_FIFO_DEPTH) ? `DBG_FIFO_AW : $clog2(DEPTH);

	dbg_entry_t    mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          push;

	assign full    = (count == (AW+1)'(DEPTH));
	assign empty_o = (count == '0);
	assign push    = wr_i && !full;
	assign head_o  = mem[rd_ptr];

	// storage
	always_ff @(posedge clk48m) begin
		if (push) begin
			mem[wr_ptr] <= wr_entry_i;
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop_i})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// entry dropped, remember it until reset
			if (wr_i && full) begin
				overflow_o <= 1'b1;
			end
		end
	end

	a_no_pop_empty: assert property (@(posedge clk48m) disable iff (rst) pop_i |-> !empty_o);
	a_count_bound: assert property (@(posedge clk48m) disable iff (rst)
		count <= (AW+1)'(DEPTH));

endmodule

`default_nettype wire

// ==== common/soc_dbg_pkg.sv ====
// Debug loader types
// Queue entry, bus write request and the misc register
// word indices used by the loader and the register block

`default_nettype none

`include "soc_dbg_defines.svh"

package soc_dbg_pkg;

	// --------------------------------------------------
	// one entry from the debug port
	// --------------------------------------------------
	// is_addr set means data is a new address pointer
	typedef struct packed {
		logic                   is_addr;
		logic [`DBG_DATA_W-1:0] data;
	} dbg_entry_t;

	// --------------------------------------------------
	// write request toward the register block
	// --------------------------------------------------
	typedef struct packed {
		logic [`DBG_DATA_W-1:0] addr;
		logic [`DBG_DATA_W-1:0] wdata;
	} bus_req_t;

	// word index inside the misc region, address bits 6..2
	typedef enum logic [4:0] {
		REG_LED       = 5'd0,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE  = 5'd19,
		// set and clear aliases of the general I/O output
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21
	} misc_reg_e;

endpackage

`default_nettype wire

// ==== common/soc_dbg_defines.svh ====
// Debug loader and misc register block
// Widths, queue sizing, the misc region code and the
// flash-select sequencer constants shared by the RTL

`ifndef SOC_DBG_DEFINES_SVH
`define SOC_DBG_DEFINES_SVH

// --------------------------------------------------
// data path
// --------------------------------------------------
`define DBG_DATA_W       32
`define DBG_FIFO_DEPTH   16
`define DBG_FIFO_AW      4

// misc region outputs
`define GENIO_W          30
`define LED_W            16

// top address nibble that selects the misc registers
`define MISC_REGION      4'h2

// --------------------------------------------------
// flash select and reload
// --------------------------------------------------
// data bits 31..8 of a flash-select write that ask for a reprogram
`define FSEL_RELOAD_KEY  24'hD0F1A5
`define FSEL_DELAY_START 3'd7
// chip select window, inclusive on both ends
`define FSEL_C_HI        3'd5
`define FSEL_C_LO        3'd3

`endif
